//--- hdl/i2f_defines.svh
// Operand width and binary32 field width and bias macros for the converter
`ifndef I2F_DEFINES_SVH
`define I2F_DEFINES_SVH

// Width of the integer operand accepted at the input
`define I2F_W 32

// Field widths of an IEEE 754 binary32 word
`define F32_EXP_W 8
`define F32_FRAC_W 23

// Exponent bias, so a stored exponent of 127 means 2^0
`define F32_BIAS 127

`endif

//--- hdl/i2f_pkg.sv
// Pipeline stage records and the binary32 result types
`include "i2f_defines.svh"

package i2f_pkg;

  // Bit index of the leading one inside an operand-wide magnitude
  typedef logic [$clog2(`I2F_W)-1:0] idx_t;

  // Record passed from magnitude extraction to normalization
  typedef struct packed {
    // High for one cycle per accepted item
    logic valid;
    // Sign of the original operand, always clear for unsigned input
    logic sign;
    // Absolute value, so the most negative signed input gives 2^31 here
    logic [`I2F_W-1:0] magnitude;
  } mag_t;

  // Record passed from normalization to rounding and packing
  typedef struct packed {
    logic valid;
    logic sign;
    // Set when the magnitude had no bit set at all
    logic zero;
    // Position of the leading one before the shift, which is the unbiased exponent
    idx_t idx;
    // Magnitude shifted left so its leading one sits in the MSB
    logic [`I2F_W-1:0] man;
  } norm_t;

  // Field view of a binary32 word, sign in the MSB
  typedef struct packed {
    logic sign;
    logic [`F32_EXP_W-1:0] exponent;
    logic [`F32_FRAC_W-1:0] fraction;
  } f32_t;

  // The result word is built through its fields and compared as raw bits
  typedef union packed {
    logic [`F32_EXP_W+`F32_FRAC_W:0] bits;
    f32_t f;
  } f32_u;

endpackage : i2f_pkg

//--- hdl/lzd.sv
// Combinational leading-one detector with a one-hot output
//
// It scans from the MSB and marks the first set bit it meets
//
//   x                            y
//   0000_0000                    0000_0000
//   0000_0001                    0000_0001
//   0011_0110                    0010_0000
//   1000_1111                    1000_0000
//
// An all-zero input gives an all-zero output, so an empty y means x was zero

module lzd #(
  // Width of the vector that is searched
  parameter int W = 32
) (
  // Vector to search for its most significant set bit
  input  logic [W-1:0] x
  // One-hot mark of that bit, or zero when nothing is set
, output logic [W-1:0] y
);

  // The search walks down from the MSB while carrying a prefix OR of the
  // bits already passed. A bit only wins while nothing above it was set
  always_comb begin
    logic seen;
    seen = 1'b0;
    for (int i = W - 1; i >= 0; i--) begin
      // Keep this bit only if no higher bit has been set so far
      y[i] = x[i] & ~seen;
      // Fold this bit into the running "a higher bit is set" term
      seen = seen | x[i];
    end
  end

  // The chain above is a ripple of OR gates. For a 32-bit operand it is
  // short enough to close timing inside the normalization stage, and a
  // synthesis tool is free to rebalance it into a tree

endmodule : lzd

//--- hdl/i2f_magnitude.sv
// Stage 1 of the converter which registers the sign and absolute value
`include "i2f_defines.svh"

module i2f_magnitude (
  input  logic                 clk
, input  logic                 rst
  // One-cycle strobe, the operand is taken in any cycle where it is high
, input  logic                 in_valid
, input  logic [`I2F_W-1:0]    operand
  // Read the operand as two's complement when set
, input  logic                 is_signed
, output i2f_pkg::mag_t        mag
);

  import i2f_pkg::*;

  // The operand is negative only when it is read as signed and its MSB is set
  logic              neg;
  // Two's-complement negation of the operand
  logic [`I2F_W-1:0] neg_operand;
  // Next value of the stage register
  mag_t              mag_d;

  assign neg = is_signed & operand[`I2F_W-1];

  // For 0x8000_0000 the negation wraps back to 0x8000_0000, which is
  // exactly 2^31 when the result is read as unsigned
  assign neg_operand = ~operand + 1'b1;

  always_comb begin
    mag_d.valid     = in_valid;
    mag_d.sign      = neg;
    mag_d.magnitude = neg ? neg_operand : operand;
  end

  // Only the valid bit is cleared by reset. Sign and magnitude are
  // don't-care while valid is low
  always_ff @(posedge clk) begin
    mag <= mag_d;
    if (rst) begin
      mag.valid <= 1'b0;
    end
  end

endmodule : i2f_magnitude

//--- hdl/i2f_normalize.sv
// Stage 2 of the converter which finds the leading one and normalizes the magnitude
`include "i2f_defines.svh"

module i2f_normalize (
  input  logic          clk
, input  logic          rst
  // Registered record from the magnitude stage
, input  i2f_pkg::mag_t mag
  // Registered record toward the rounding stage
, output i2f_pkg::norm_t norm
);

  import i2f_pkg::*;

  // One-hot mark of the most significant set bit of the magnitude
  logic [`I2F_W-1:0] lead_onehot;
  // Binary position of that bit
  idx_t              lead_idx;
  // Left shift that moves the leading one into the MSB
  idx_t              shamt;
  // Set when the magnitude is zero and the detector found nothing
  logic              is_zero;
  // Next value of the stage register
  norm_t             norm_d;

  // Search the magnitude for its first 1 from the MSB
  lzd #(
    .W (`I2F_W)
  ) u_lzd (
    .x (mag.magnitude)
  , .y (lead_onehot)
  );

  // One-hot to binary encoder. Since at most one bit is set, OR-ing the
  // indices of all set bits gives the index of the one that is set
  always_comb begin
    lead_idx = '0;
    for (int i = 0; i < `I2F_W; i++) begin
      if (lead_onehot[i]) begin
        lead_idx = lead_idx | idx_t'(i);
      end
    end
  end

  // An empty one-hot vector can only come from a zero magnitude
  assign is_zero = ~|lead_onehot;

  // The leading one at index k needs a shift of (W - 1 - k) to reach the MSB
  assign shamt = idx_t'(`I2F_W - 1) - lead_idx;

  always_comb begin
    norm_d.valid = mag.valid;
    norm_d.sign  = mag.sign;
    norm_d.zero  = is_zero;
    // The index of the leading one is the unbiased exponent of the result
    norm_d.idx   = lead_idx;
    // For a zero input the shift is irrelevant because the result is all zeros
    norm_d.man   = mag.magnitude << shamt;
  end

  // Only the valid bit is cleared by reset
  always_ff @(posedge clk) begin
    norm <= norm_d;
    if (rst) begin
      norm.valid <= 1'b0;
    end
  end

endmodule : i2f_normalize

//--- hdl/i2f_round_pack.sv
// Stage 3 of the converter which rounds to nearest even and packs the binary32 word
`include "i2f_defines.svh"

module i2f_round_pack (
  input  logic           clk
, input  logic           rst
  // Registered record from the normalization stage
, input  i2f_pkg::norm_t norm
  // One-cycle strobe that marks a new result
, output logic           out_valid
, output i2f_pkg::f32_u  result
);

  import i2f_pkg::*;

  localparam int EXP_W  = `F32_EXP_W;
  localparam int FRAC_W = `F32_FRAC_W;
  // Bit of the normalized magnitude just below the kept fraction
  localparam int G_BIT  = `I2F_W - 2 - FRAC_W;

  // Fraction bits below the hidden leading one, before rounding
  logic [FRAC_W-1:0] frac_trunc;
  // First dropped bit
  logic              guard;
  // OR of every dropped bit below the guard bit
  logic              sticky;
  // Increment the fraction
  logic              round_up;
  // Fraction plus rounding increment, with room for the carry out
  logic [FRAC_W:0]   frac_sum;
  // Biased exponent before and after the carry is applied
  logic [EXP_W-1:0]  exp_base;
  logic [EXP_W-1:0]  exp_final;
  // Next value of the result register
  f32_u              packed_d;

  // Bit 31 of the magnitude is the hidden one and is not stored
  assign frac_trunc = norm.man[`I2F_W-2 -: FRAC_W];
  assign guard      = norm.man[G_BIT];
  assign sticky     = |norm.man[G_BIT-1:0];

  // Round up above the halfway point, or exactly on it when the kept
  // fraction is odd so that ties go to the even neighbour
  assign round_up = guard & (sticky | frac_trunc[0]);

  assign frac_sum = {1'b0, frac_trunc} + {{FRAC_W{1'b0}}, round_up};

  // The leading-one index is the power of two of the value
  assign exp_base = EXP_W'(norm.idx) + EXP_W'(`F32_BIAS);

  // A carry out means the fraction was all ones and wrapped to zero, so
  // the value moved up to the next power of two
  assign exp_final = exp_base + EXP_W'(frac_sum[FRAC_W]);

  always_comb begin
    if (norm.zero) begin
      // Zero has no leading one and packs as positive zero
      packed_d.bits = '0;
    end else begin
      packed_d.f.sign     = norm.sign;
      packed_d.f.exponent = exp_final;
      // On a carry these low bits are already zero
      packed_d.f.fraction = frac_sum[FRAC_W-1:0];
    end
  end

  // The result word holds no state of its own and is not reset
  always_ff @(posedge clk) begin
    result <= packed_d;
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= norm.valid;
    end
  end

endmodule : i2f_round_pack

//--- hdl/i2f_top.sv
// Top level of the three-stage integer to binary32 converter
`include "i2f_defines.svh"

module i2f_top (
  input  logic              clk
, input  logic              rst
  // A strobe at edge N gives out_valid at edge N+3
, input  logic              in_valid
, input  logic [`I2F_W-1:0] operand
, input  logic              is_signed
  // There is no back-pressure, so each result must be taken when it appears
, output logic              out_valid
, output i2f_pkg::f32_u     result
);

  import i2f_pkg::*;

  // Stage 1 to stage 2 record
  mag_t  mag;
  // Stage 2 to stage 3 record
  norm_t norm;

  // Sign and absolute value of the operand
  i2f_magnitude u_magnitude (
    .clk       (clk)
  , .rst       (rst)
  , .in_valid  (in_valid)
  , .operand   (operand)
  , .is_signed (is_signed)
  , .mag       (mag)
  );

  // Leading-one search and left shift of the magnitude
  i2f_normalize u_normalize (
    .clk  (clk)
  , .rst  (rst)
  , .mag  (mag)
  , .norm (norm)
  );

  // Round to nearest even and build the binary32 word
  i2f_round_pack u_round_pack (
    .clk       (clk)
  , .rst       (rst)
  , .norm      (norm)
  , .out_valid (out_valid)
  , .result    (result)
  );

endmodule : i2f_top

//--- tests/i2f_chk.sv
// Concurrent assertions on the converter pipeline and their bind to the top level

module i2f_chk (
  input logic          clk
, input logic          rst
, input logic          in_valid
, input logic          out_valid
, input i2f_pkg::f32_u result
);

  // Reset is synchronous, so out_valid is low from the edge after rst is seen
  property p_reset_clears;
    @(posedge clk) rst |=> !out_valid;
  endproperty

  // Fixed latency of three edges from capture to result
  property p_latency;
    @(posedge clk) disable iff (rst) out_valid == $past(in_valid, 3);
  endproperty

  // Zero always packs with a clear sign bit
  property p_no_neg_zero;
    @(posedge clk) out_valid |-> result.bits != {1'b1, 31'h0};
  endproperty

  a_reset_clears: assert property (p_reset_clears)
    else $error("out_valid high after reset");
  a_latency: assert property (p_latency)
    else $error("out_valid does not follow in_valid by three cycles");
  a_no_neg_zero: assert property (p_no_neg_zero)
    else $error("negative zero on result");

endmodule : i2f_chk

bind i2f_top i2f_chk u_chk (
  .clk       (clk)
, .rst       (rst)
, .in_valid  (in_valid)
, .out_valid (out_valid)
, .result    (result)
);

//--- tests/tb_i2f.sv
// Directed testbench for the integer to binary32 converter with reference model and result monitor
`include "i2f_defines.svh"

module tb_i2f;

  import i2f_pkg::*;

  // Cycles from the drive edge until the monitor sees out_valid
  // The DUT captures one edge after the drive and answers three edges later
  localparam int SAMPLE_LAT = 4;
  localparam int DRAIN_LIMIT = 40;
  localparam int RUN_LIMIT = 20000;

  logic              clk;
  logic              rst;
  logic              in_valid;
  logic [`I2F_W-1:0] operand;
  logic              is_signed;
  logic              out_valid;
  f32_u              result;

  // Expected words and their drive cycles kept in issue order
  logic [31:0] exp_q[$];
  int          cyc_q[$];
  int          cyc;
  int          errors;
  int          checks;
  int          out_count;
  logic        rst_q;

  i2f_top u_i2f_top (
    .clk       (clk)
  , .rst       (rst)
  , .in_valid  (in_valid)
  , .operand   (operand)
  , .is_signed (is_signed)
  , .out_valid (out_valid)
  , .result    (result)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Expected binary32 word built from the value itself. Rounding compares
  // the dropped remainder with half an ulp
  function automatic logic [31:0] ref_f32(input logic [31:0] op, input logic sgn);
    logic            neg;
    longint unsigned m;
    longint unsigned kept;
    longint unsigned rem;
    longint unsigned half;
    int              k;
    int              sh;
    neg = sgn && op[31];
    m = neg ? (64'h1_0000_0000 - {32'h0, op}) : {32'h0, op};
    if (m == 0) begin
      return 32'h0;
    end
    k = 0;
    for (int i = 0; i < 33; i++) begin
      if (m[i]) begin
        k = i;
      end
    end
    if (k <= 23) begin
      kept = m << (23 - k);
    end else begin
      sh = k - 23;
      kept = m >> sh;
      rem = m & ((64'd1 << sh) - 64'd1);
      half = 64'd1 << (sh - 1);
      // Above half goes up, exactly half goes to the even neighbour
      if (rem > half || (rem == half && kept[0])) begin
        kept = kept + 64'd1;
      end
      // Rounding past 24 significant bits moves to the next power of two
      if (kept == (64'd1 << 24)) begin
        kept = kept >> 1;
        k = k + 1;
      end
    end
    return {neg, 8'(k + 127), kept[22:0]};
  endfunction

  // One item on the input; the next call or idle() moves the strobe on
  task automatic send(input logic [31:0] op, input logic sgn, input logic [31:0] want);
    @(posedge clk);
    in_valid  <= 1'b1;
    operand   <= op;
    is_signed <= sgn;
    exp_q.push_back(want);
    cyc_q.push_back(cyc);
  endtask

  // Hand-computed words also confirm the model agrees with them
  task automatic send_known(input logic [31:0] op, input logic sgn, input logic [31:0] want);
    if (ref_f32(op, sgn) !== want) begin
      $display("FAILED at %0t: ref_f32 expected %08h got %08h", $time, want, ref_f32(op, sgn));
      errors++;
    end
    send(op, sgn, want);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // Waits until every issued item has come back or the limit runs out
  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR at %0t: %0d results never appeared", $time, exp_q.size());
      errors++;
      exp_q.delete();
      cyc_q.delete();
    end
  endtask

  // Holds reset for n edges and forgets whatever was in flight
  task automatic apply_reset(input int n);
    @(posedge clk);
    rst      <= 1'b1;
    in_valid <= 1'b0;
    repeat (n) @(posedge clk);
    exp_q.delete();
    cyc_q.delete();
    rst <= 1'b0;
  endtask

  // The result monitor reads the values settled before each edge
  always @(posedge clk) begin
    logic [31:0] want;
    int          issued;
    rst_q <= rst;
    if (out_valid && rst_q) begin
      $display("ERROR at %0t: out_valid high after reset was applied", $time);
      errors++;
    end else if (out_valid && !rst) begin
      out_count++;
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t: out_valid high with no item in flight", $time);
        errors++;
      end else begin
        want = exp_q.pop_front();
        issued = cyc_q.pop_front();
        checks++;
        if (result.bits !== want) begin
          $display("FAILED at %0t: result expected %08h got %08h", $time, want, result.bits);
          errors++;
        end
        if (cyc - issued != SAMPLE_LAT) begin
          $display("FAILED at %0t: latency expected %0d got %0d", $time, SAMPLE_LAT,
                   cyc - issued);
          errors++;
        end
      end
    end
  end

  task automatic exact_values();
    for (int s = 0; s < 2; s++) begin
      send_known(32'h0000_0000, 1'(s), 32'h0000_0000);
      send_known(32'h0000_0001, 1'(s), 32'h3F80_0000);
      send_known(32'h0000_0002, 1'(s), 32'h4000_0000);
      send_known(32'h0000_0400, 1'(s), 32'h4480_0000);
      send_known(32'h4000_0000, 1'(s), 32'h4E80_0000);
      send_known(32'h00FF_FFFF, 1'(s), 32'h4B7F_FFFF);
    end
    send_known(32'hFFFF_FFFF, 1'b1, 32'hBF80_0000);
    send_known(32'hFFFF_FFFE, 1'b1, 32'hC000_0000);
    send_known(32'hFFFF_FFFF, 1'b0, 32'h4F80_0000);
    idle(1);
    wait_drain(DRAIN_LIMIT);
  endtask

  task automatic round_nearest_even();
    // Tie with an even kept fraction stays, tie with an odd one rounds up
    send_known(32'h0100_0001, 1'b0, 32'h4B80_0000);
    send_known(32'h0100_0001, 1'b1, 32'h4B80_0000);
    send_known(32'h0100_0003, 1'b0, 32'h4B80_0002);
    // Guard and sticky both set
    send_known(32'h0200_0003, 1'b0, 32'h4C00_0001);
    send_known(32'hFEFF_FFFD, 1'b1, 32'hCB80_0002);
    // All-ones fraction carries into the exponent
    send_known(32'hFFFF_FFFF, 1'b0, 32'h4F80_0000);
    idle(1);
    wait_drain(DRAIN_LIMIT);
  endtask

  task automatic signed_extremes();
    send_known(32'h8000_0000, 1'b1, 32'hCF00_0000);
    send_known(32'h8000_0000, 1'b0, 32'h4F00_0000);
    send_known(32'h7FFF_FFFF, 1'b1, 32'h4F00_0000);
    send_known(32'h7FFF_FFFF, 1'b0, 32'h4F00_0000);
    idle(1);
    wait_drain(DRAIN_LIMIT);
  endtask

  task automatic back_to_back_burst();
    logic [31:0] op;
    logic        sgn;
    for (int i = 0; i < 200; i++) begin
      op = $urandom();
      sgn = 1'($urandom_range(0, 1));
      send(op, sgn, ref_f32(op, sgn));
    end
    idle(1);
    wait_drain(DRAIN_LIMIT);
  endtask

  task automatic sparse_strobes();
    logic [31:0] op;
    logic        sgn;
    int          start;
    start = out_count;
    for (int i = 0; i < 60; i++) begin
      op = $urandom();
      sgn = 1'($urandom_range(0, 1));
      send(op, sgn, ref_f32(op, sgn));
      idle(int'($urandom_range(0, 4)));
    end
    idle(1);
    wait_drain(DRAIN_LIMIT);
    if (out_count - start != 60) begin
      $display("FAILED at %0t: result count expected 60 got %0d", $time, out_count - start);
      errors++;
    end
  endtask

  task automatic reset_mid_burst();
    int start;
    for (int i = 0; i < 5; i++) begin
      send(32'h0000_1000 + 32'(i), 1'b0, ref_f32(32'h0000_1000 + 32'(i), 1'b0));
    end
    apply_reset(10);
    // The monitor flags any out_valid here because nothing is in flight
    start = out_count;
    idle(6);
    if (out_count != start) begin
      $display("ERROR at %0t: results appeared after reset with no new input", $time);
      errors++;
    end
    send_known(32'hFFFF_FFFF, 1'b1, 32'hBF80_0000);
    send_known(32'h0000_0001, 1'b0, 32'h3F80_0000);
    idle(1);
    wait_drain(DRAIN_LIMIT);
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    rst_q     = 1'b1;
    in_valid  = 1'b0;
    operand   = '0;
    is_signed = 1'b0;
    cyc       = 0;
    errors    = 0;
    checks    = 0;
    out_count = 0;
    void'($urandom(73));
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    idle(3);
    exact_values();
    round_nearest_even();
    signed_extremes();
    back_to_back_burst();
    sparse_strobes();
    reset_mid_burst();
    idle(4);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Stops a run that never reaches its end
  initial begin
    repeat (RUN_LIMIT) @(posedge clk);
    $display("ERROR: run did not finish within %0d cycles", RUN_LIMIT);
    $display("Simulation failed");
    $finish;
  end

endmodule : tb_i2f

//--- all.f
+incdir+hdl
hdl/i2f_pkg.sv
hdl/lzd.sv
hdl/i2f_magnitude.sv
hdl/i2f_normalize.sv
hdl/i2f_round_pack.sv
hdl/i2f_top.sv
tests/i2f_chk.sv
tests/tb_i2f.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_i2f
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
